// File: bench/lsu_ctl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_ctl_tb
   import lsu_map_pkg::*;
   import lsu_pkt_pkg::*;
();

   localparam int OP_NOP = 0;
   localparam int OP_LD  = 1;
   localparam int OP_ST  = 2;
   localparam int OP_LR  = 3;
   localparam int OP_SC  = 4;

   localparam logic [1:0] SZ_B = 2'd0;
   localparam logic [1:0] SZ_H = 2'd1;
   localparam logic [1:0] SZ_W = 2'd2;

   localparam lsu_region_t R_DCCM = 3'b100;
   localparam lsu_region_t R_PIC  = 3'b010;
   localparam lsu_region_t R_EXT  = 3'b001;
   localparam lsu_fault_t  F_NONE = 2'b00;
   localparam lsu_fault_t  F_MIS  = 2'b10;
   localparam lsu_fault_t  F_ACC  = 2'b01;
   localparam data_t       JUNK   = 32'h5a5a_a5a5; // On the sources that are not selected

   // Per-cycle flush and lr_reset vectors, bit 1 is thread 1
   typedef struct packed {
      logic [1:0] f2;
      logic [1:0] f3;
      logic [1:0] f4;
      logic [1:0] f5;
      logic [1:0] lrr;
   } ctl_t;

   localparam ctl_t NOF    = 10'b00_00_00_00_00;
   localparam ctl_t F2_T0  = 10'b01_00_00_00_00;
   localparam ctl_t F3_T1  = 10'b00_10_00_00_00;
   localparam ctl_t F4_T0  = 10'b00_00_01_00_00;
   localparam ctl_t F5_T0  = 10'b00_00_00_01_00;
   localparam ctl_t LRR_T1 = 10'b00_00_00_00_10;

   typedef struct packed {
      lsu_pkt_t    pkt;
      addr_t       rs1;
      offset_t     offset;
      ctl_t        ctl;
      data_t       dccm;
      data_t       pic;
      data_t       bus;
      addr_t       e_addr;
      lsu_region_t e_region;
      lsu_fault_t  e_fault;
      data_t       e_result;
      logic        e_commit;
      logic        e_sc;
      logic [1:0]  e_lr;    // lr_vld in this row's own cycle
   } row_t;

   row_t rows[$];

   logic        clk;
   logic        arst_n;
   lsu_pkt_t    lsu_p;
   addr_t       rs1;
   offset_t     offset;
   logic [1:0]  flush_dc2_up;
   logic [1:0]  flush_dc3;
   logic [1:0]  flush_dc4;
   logic [1:0]  flush_dc5;
   logic [1:0]  lr_reset;
   data_t       dccm_rdata;
   data_t       pic_rdata;
   data_t       bus_rdata;
   addr_t       lsu_addr_dc3;
   lsu_region_t region_dc3;
   lsu_fault_t  fault_dc3;
   data_t       lsu_result_dc3;
   logic        lsu_commit_dc5;
   logic        sc_success_dc5;
   logic [1:0]  lr_vld;

   lsu_ctl lsu_ctl_inst (
      .clk            (clk),
      .arst_n         (arst_n),
      .lsu_p          (lsu_p),
      .rs1            (rs1),
      .offset         (offset),
      .flush_dc2_up   (flush_dc2_up),
      .flush_dc3      (flush_dc3),
      .flush_dc4      (flush_dc4),
      .flush_dc5      (flush_dc5),
      .lr_reset       (lr_reset),
      .dccm_rdata     (dccm_rdata),
      .pic_rdata      (pic_rdata),
      .bus_rdata      (bus_rdata),
      .lsu_addr_dc3   (lsu_addr_dc3),
      .region_dc3     (region_dc3),
      .fault_dc3      (fault_dc3),
      .lsu_result_dc3 (lsu_result_dc3),
      .lsu_commit_dc5 (lsu_commit_dc5),
      .sc_success_dc5 (sc_success_dc5),
      .lr_vld         (lr_vld)
   );

   always #4 clk = ~clk;

   // **********************************************************
   // Failure reporting and compare tasks
   // **********************************************************
   task automatic stop_run(input string line);
      $display("%s", line);
      $display("Simulation FAILED");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_addr(input string what, input addr_t got, input addr_t exp);
      if (got !== exp) begin
         stop_run($sformatf("FAILED at %0t ns: %s expected %h got %h", $time, what, exp, got));
      end
   endtask

   task automatic check_region(input string what, input lsu_region_t got,
                               input lsu_region_t exp);
      if (got !== exp) begin
         stop_run($sformatf("FAILED at %0t ns: %s expected %b got %b", $time, what, exp, got));
      end
   endtask

   task automatic check_fault(input string what, input lsu_fault_t got, input lsu_fault_t exp);
      if (got !== exp) begin
         stop_run($sformatf("FAILED at %0t ns: %s expected %b got %b", $time, what, exp, got));
      end
   endtask

   task automatic check_data(input string what, input data_t got, input data_t exp);
      if (got !== exp) begin
         stop_run($sformatf("FAILED at %0t ns: %s expected %h got %h", $time, what, exp, got));
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         stop_run($sformatf("FAILED at %0t ns: %s expected %b got %b", $time, what, exp, got));
      end
   endtask

   // **********************************************************
   // Table building
   // **********************************************************
   function automatic lsu_pkt_t make_op(input int kind, input logic tid, input logic [1:0] size,
                                        input logic uns);
      lsu_pkt_t p;
      p        = '0;
      p.valid  = (kind != OP_NOP);
      p.tid    = tid;
      p.load   = (kind == OP_LD) || (kind == OP_LR);
      p.store  = (kind == OP_ST) || (kind == OP_SC);
      p.atomic = (kind == OP_LR) || (kind == OP_SC);
      p.lr     = (kind == OP_LR);
      p.sc     = (kind == OP_SC);
      p.unsign = uns;
      p.by     = (size == SZ_B) && !p.atomic;
      p.half   = (size == SZ_H) && !p.atomic;
      p.word   = (size == SZ_W) || p.atomic; // LR and SC are always words
      return p;
   endfunction

   task automatic add_row(input lsu_pkt_t pkt, input addr_t rs1_v, input offset_t off,
                          input ctl_t c, input data_t d_dccm, input data_t d_pic,
                          input data_t d_bus, input addr_t e_addr, input lsu_region_t e_region,
                          input lsu_fault_t e_fault, input data_t e_result,
                          input logic e_commit, input logic e_sc, input logic [1:0] e_lr);
      row_t r;
      r.pkt      = pkt;
      r.rs1      = rs1_v;
      r.offset   = off;
      r.ctl      = c;
      r.dccm     = d_dccm;
      r.pic      = d_pic;
      r.bus      = d_bus;
      r.e_addr   = e_addr;
      r.e_region = e_region;
      r.e_fault  = e_fault;
      r.e_result = e_result;
      r.e_commit = e_commit;
      r.e_sc     = e_sc;
      r.e_lr     = e_lr;
      rows.push_back(r);
   endtask

   // Invalid byte at the DCCM base
   task automatic add_idle(input ctl_t c, input logic [1:0] e_lr);
      add_row(make_op(OP_NOP, 0, SZ_B, 0), 32'hf004_0000, 12'h000, c,
         JUNK, JUNK, JUNK, 32'hf004_0000, R_DCCM, F_NONE, 32'h0, 0, 0, e_lr);
   endtask

   task automatic build_table();
      // Address, region and load formatting
      add_row(make_op(OP_LD, 0, SZ_W, 0), 32'hf004_0100, 12'h010, NOF,
         32'h8765_4321, JUNK, JUNK, 32'hf004_0110, R_DCCM, F_NONE, 32'h8765_4321, 1, 0, 2'b00);
      add_row(make_op(OP_LD, 1, SZ_B, 0), 32'hf004_0200, 12'hfff, NOF,
         32'h0000_0080, JUNK, JUNK, 32'hf004_01ff, R_DCCM, F_NONE, 32'hffff_ff80, 1, 0, 2'b00);
      add_row(make_op(OP_LD, 0, SZ_B, 1), 32'h0000_1000, 12'h7ff, NOF,
         JUNK, JUNK, 32'h1234_56f0, 32'h0000_17ff, R_EXT, F_NONE, 32'h0000_00f0, 1, 0, 2'b00);
      add_row(make_op(OP_LD, 0, SZ_H, 0), 32'h2000_0000, 12'h802, NOF,
         JUNK, JUNK, 32'h0000_9abc, 32'h1fff_f802, R_EXT, F_NONE, 32'hffff_9abc, 1, 0, 2'b00);
      add_row(make_op(OP_LD, 1, SZ_H, 1), 32'hf004_1000, 12'h002, NOF,
         32'hffff_9abc, JUNK, JUNK, 32'hf004_1002, R_DCCM, F_NONE, 32'h0000_9abc, 1, 0, 2'b00);
      add_row(make_op(OP_LD, 0, SZ_W, 0), 32'hf00c_0000, 12'h040, NOF,
         JUNK, 32'hcafe_f00d, JUNK, 32'hf00c_0040, R_PIC, F_NONE, 32'hcafe_f00d, 1, 0, 2'b00);
      // LR with an offset that must be ignored, then SC pass and fail
      add_row(make_op(OP_LR, 0, SZ_W, 0), 32'hf004_0400, 12'h123, NOF,
         32'h1357_9bdf, JUNK, JUNK, 32'hf004_0400, R_DCCM, F_NONE, 32'h1357_9bdf, 1, 0, 2'b00);
      add_row(make_op(OP_ST, 1, SZ_W, 0), 32'h0000_2000, 12'h000, NOF,
         JUNK, JUNK, JUNK, 32'h0000_2000, R_EXT, F_NONE, 32'h0, 1, 0, 2'b00);
      add_row(make_op(OP_SC, 0, SZ_W, 0), 32'hf004_0400, 12'h010, NOF,
         JUNK, JUNK, JUNK, 32'hf004_0400, R_DCCM, F_NONE, 32'h0, 1, 1, 2'b00);
      add_row(make_op(OP_SC, 0, SZ_W, 0), 32'hf004_0400, 12'h000, NOF,
         JUNK, JUNK, JUNK, 32'hf004_0400, R_DCCM, F_NONE, 32'h0, 1, 0, 2'b00);
      add_row(make_op(OP_LR, 1, SZ_W, 0), 32'hf004_0800, 12'h000, NOF,
         32'h0000_0042, JUNK, JUNK, 32'hf004_0800, R_DCCM, F_NONE, 32'h0000_0042, 1, 0, 2'b00);
      add_row(make_op(OP_SC, 1, SZ_W, 0), 32'hf004_0804, 12'h000, NOF,
         JUNK, JUNK, JUNK, 32'hf004_0804, R_DCCM, F_NONE, 32'h0, 1, 0, 2'b00);
      // Faults
      add_row(make_op(OP_LD, 0, SZ_H, 0), 32'h0000_3001, 12'h000, NOF,
         JUNK, JUNK, 32'h0000_7f7f, 32'h0000_3001, R_EXT, F_MIS, 32'h0000_7f7f, 1, 0, 2'b01);
      add_row(make_op(OP_ST, 1, SZ_W, 0), 32'h0000_3000, 12'h006, NOF,
         JUNK, JUNK, JUNK, 32'h0000_3006, R_EXT, F_MIS, 32'h0, 1, 0, 2'b01);
      add_row(make_op(OP_LD, 1, SZ_W, 0), 32'hf004_fffe, 12'h000, NOF,
         32'h2468_ace0, JUNK, JUNK, 32'hf004_fffe, R_DCCM, F_ACC, 32'h2468_ace0, 1, 0, 2'b00);
      add_row(make_op(OP_LD, 1, SZ_H, 0), 32'hf00c_0010, 12'h000, NOF,
         JUNK, 32'h0000_8123, JUNK, 32'hf00c_0010, R_PIC, F_ACC, 32'hffff_8123, 1, 0, 2'b00);
      // The two rows before the decode kill are thread 1
      add_row(make_op(OP_LD, 0, SZ_W, 0), 32'hf004_0020, 12'h000, F2_T0,
         32'h0bad_beef, JUNK, JUNK, 32'hf004_0020, R_DCCM, F_NONE, 32'h0, 0, 0, 2'b10);
      add_row(make_op(OP_LD, 0, SZ_W, 0), 32'hf004_0010, 12'h000, NOF,
         32'h0bad_beef, JUNK, JUNK, 32'hf004_0010, R_DCCM, F_NONE, 32'h0bad_beef, 0, 0, 2'b00);
      add_row(make_op(OP_LD, 1, SZ_W, 0), 32'hf004_0014, 12'h000, NOF,
         32'h7777_0001, JUNK, JUNK, 32'hf004_0014, R_DCCM, F_NONE, 32'h7777_0001, 1, 0, 2'b00);
      // Reservation clearing
      add_row(make_op(OP_LR, 0, SZ_W, 0), 32'hf004_0500, 12'h000, NOF,
         32'h0000_0001, JUNK, JUNK, 32'hf004_0500, R_DCCM, F_NONE, 32'h0000_0001, 1, 0, 2'b00);
      add_row(make_op(OP_LR, 1, SZ_W, 0), 32'hf004_0600, 12'h000, NOF,
         32'h0000_0002, JUNK, JUNK, 32'hf004_0600, R_DCCM, F_NONE, 32'h0000_0002, 1, 0, 2'b00);
      add_row(make_op(OP_ST, 1, SZ_W, 0), 32'hf004_0504, 12'h000, NOF,
         JUNK, JUNK, JUNK, 32'hf004_0504, R_DCCM, F_NONE, 32'h0, 1, 0, 2'b00);
      add_row(make_op(OP_ST, 1, SZ_B, 0), 32'hf004_0502, 12'h000, F5_T0, // Hits row 17 at dc5
         JUNK, JUNK, JUNK, 32'hf004_0502, R_DCCM, F_NONE, 32'h0, 1, 0, 2'b00);
      add_idle(F5_T0, 2'b00);   // Row 18 is thread 1
      add_idle(NOF, 2'b00);
      add_idle(NOF, 2'b01);
      add_idle(NOF, 2'b11);
      add_idle(NOF, 2'b11);
      add_idle(LRR_T1, 2'b10);
      add_idle(NOF, 2'b00);
      // Late flushes still show the dc3 data
      add_row(make_op(OP_LD, 1, SZ_W, 0), 32'hf004_0030, 12'h000, NOF,
         32'h1111_0030, JUNK, JUNK, 32'hf004_0030, R_DCCM, F_NONE, 32'h1111_0030, 0, 0, 2'b00);
      add_row(make_op(OP_LD, 0, SZ_W, 0), 32'hf004_0034, 12'h000, NOF,
         32'h2222_0034, JUNK, JUNK, 32'hf004_0034, R_DCCM, F_NONE, 32'h2222_0034, 0, 0, 2'b00);
      add_row(make_op(OP_LD, 0, SZ_W, 0), 32'hf004_0038, 12'h000, NOF,
         32'h3333_0038, JUNK, JUNK, 32'hf004_0038, R_DCCM, F_NONE, 32'h3333_0038, 1, 0, 2'b00);
      add_idle(F3_T1, 2'b00);           // Row 30 at dc3
      add_idle(NOF, 2'b00);
      add_idle(F3_T1 | F4_T0, 2'b00);   // Row 31 at dc4, row 32 at dc3
      // Decode flush also kills what sits in dc1 and dc2
      add_row(make_op(OP_LD, 0, SZ_W, 0), 32'hf004_0040, 12'h000, NOF,
         32'h4444_0040, JUNK, JUNK, 32'hf004_0040, R_DCCM, F_NONE, 32'h0, 0, 0, 2'b00);
      add_row(make_op(OP_LD, 0, SZ_W, 0), 32'hf004_0044, 12'h000, NOF,
         32'h5555_0044, JUNK, JUNK, 32'hf004_0044, R_DCCM, F_NONE, 32'h0, 0, 0, 2'b00);
      add_idle(F2_T0, 2'b00);   // Row 36 at dc2, row 37 at dc1
   endtask

   // **********************************************************
   // Driving and checking
   // **********************************************************
   task automatic drive_ops(input row_t r);
      lsu_p        = r.pkt;
      rs1          = r.rs1;
      offset       = r.offset;
      flush_dc2_up = r.ctl.f2;
      flush_dc3    = r.ctl.f3;
      flush_dc4    = r.ctl.f4;
      flush_dc5    = r.ctl.f5;
      lr_reset     = r.ctl.lrr;
   endtask

   task automatic drive_rdata(input row_t r);
      dccm_rdata = r.dccm;
      pic_rdata  = r.pic;
      bus_rdata  = r.bus;
   endtask

   task automatic check_dc3(input int i);
      row_t r;
      r = rows[i];
      check_addr($sformatf("row %0d lsu_addr_dc3", i), lsu_addr_dc3, r.e_addr);
      check_region($sformatf("row %0d region_dc3", i), region_dc3, r.e_region);
      check_fault($sformatf("row %0d fault_dc3", i), fault_dc3, r.e_fault);
      check_data($sformatf("row %0d lsu_result_dc3", i), lsu_result_dc3, r.e_result);
   endtask

   task automatic check_dc5(input int i);
      check_bit($sformatf("row %0d lsu_commit_dc5", i), lsu_commit_dc5, rows[i].e_commit);
      check_bit($sformatf("row %0d sc_success_dc5", i), sc_success_dc5, rows[i].e_sc);
   endtask

   // Watchdog
   initial begin
      @(posedge arst_n);
      #((rows.size() + 20) * 8);
      stop_run("Timeout: the test loop did not finish in the allowed time");
   end

   initial begin
      int n;
      clk    = 1'b0;
      arst_n = 1'b0;
      build_table();
      n = rows.size();
      drive_ops(make_idle_row());
      drive_rdata(make_idle_row());
      repeat (8) @(posedge clk);
      #1 arst_n = 1'b1;

      // Row i sampled at the edge after iteration i, at dc3 in i+3, at dc5 in i+5
      for (int cyc = 0; cyc < n + 6; cyc++) begin
         @(posedge clk);
         #1;
         if (cyc < n) begin
            drive_ops(rows[cyc]);
         end else begin
            drive_ops(make_idle_row());
         end
         if (cyc >= 3 && cyc - 3 < n) begin
            drive_rdata(rows[cyc - 3]);
         end
         #3;
         if (cyc >= 3 && cyc - 3 < n) begin
            check_dc3(cyc - 3);
         end
         if (cyc >= 5 && cyc - 5 < n) begin
            check_dc5(cyc - 5);
         end
         if (cyc < n) begin
            check_bit($sformatf("cycle %0d lr_vld[0]", cyc), lr_vld[0], rows[cyc].e_lr[0]);
            check_bit($sformatf("cycle %0d lr_vld[1]", cyc), lr_vld[1], rows[cyc].e_lr[1]);
         end
      end

      $display("Simulation PASSED");
      $finish;
   end

   function automatic row_t make_idle_row();
      row_t r;
      r      = '0;
      r.rs1  = 32'hf004_0000;
      r.dccm = JUNK;
      r.pic  = JUNK;
      r.bus  = JUNK;
      return r;
   endfunction

endmodule

`default_nettype wire

// File: lsu_ctl.f
source/lsu_map_pkg.sv
source/lsu_pkt_pkg.sv
source/lsu_addr_gen.sv
source/lsu_pkt_pipe.sv
source/lsu_load_format.sv
source/lsu_reservation.sv
source/lsu_ctl.sv
bench/lsu_ctl_tb.sv

// File: source/lsu_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_addr_gen
   import lsu_map_pkg::*;
   import lsu_pkt_pkg::*;
#(
   parameter addr_t       DCCM_BASE      = DEF_DCCM_BASE,
   parameter int unsigned DCCM_SIZE_LOG2 = DEF_DCCM_SIZE_LOG2,
   parameter addr_t       PIC_BASE       = DEF_PIC_BASE,
   parameter int unsigned PIC_SIZE_LOG2  = DEF_PIC_SIZE_LOG2,
   parameter int unsigned NUM_THREADS    = DEF_NUM_THREADS
)(
   input  logic                   clk,
   input  logic                   arst_n,
   input  lsu_pkt_t               lsu_p,
   input  addr_t                  rs1,
   input  offset_t                offset,
   input  logic [NUM_THREADS-1:0] flush_dc2_up,
   output lsu_pkt_t               pkt_dc1,
   output addr_t                  addr_dc1,
   output lsu_region_t            region_dc1,
   output lsu_fault_t             fault_dc1
);

   lsu_pkt_t    pkt_in;
   addr_t       rs1_dc1;
   offset_t     offset_dc1;
   offset_t     offset_eff;
   addr_t       size_ofs;
   addr_t       end_addr_dc1;
   lsu_region_t end_region_dc1;

   // Address falls in the naturally aligned window at base
   function automatic logic in_window(input addr_t a, input addr_t base,
                                      input int unsigned size_log2);
      return (a >> size_log2) == (base >> size_log2);
   endfunction

   function automatic lsu_region_t decode_region(input addr_t a);
      lsu_region_t r;
      r.in_dccm  = in_window(a, DCCM_BASE, DCCM_SIZE_LOG2);
      r.in_pic   = in_window(a, PIC_BASE, PIC_SIZE_LOG2);
      r.external = ~r.in_dccm & ~r.in_pic;
      return r;
   endfunction

   // **********************************************************
   // Decode to dc1 operand flops
   // **********************************************************
   always_comb begin
      pkt_in       = lsu_p;
      pkt_in.valid = lsu_p.valid & ~flush_dc2_up[lsu_p.tid];
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pkt_dc1 <= '0;
      end else begin
         pkt_dc1 <= pkt_in;
      end
   end

   always_ff @(posedge clk) begin
      rs1_dc1    <= rs1;
      offset_dc1 <= offset;
   end

   // **********************************************************
   // Start and end address
   // **********************************************************
   assign offset_eff = offset_dc1 & ~{12{pkt_dc1.atomic}}; // AMO uses rs1 only
   assign addr_dc1   = rs1_dc1 + {{20{offset_eff[11]}}, offset_eff};

   assign size_ofs     = {30'b0, pkt_dc1.word, pkt_dc1.half | pkt_dc1.word};
   assign end_addr_dc1 = addr_dc1 + size_ofs;

   assign region_dc1     = decode_region(addr_dc1);
   assign end_region_dc1 = decode_region(end_addr_dc1);

   // DCCM takes unaligned accesses, other spaces do not
   assign fault_dc1.misaligned = ~region_dc1.in_dccm &
                                 ((pkt_dc1.half & addr_dc1[0]) |
                                  (pkt_dc1.word & (|addr_dc1[1:0])));

   // Crossing a region edge, or a PIC access narrower than a word
   assign fault_dc1.access = (region_dc1 != end_region_dc1) |
                             (region_dc1.in_pic & ~pkt_dc1.word);

endmodule

`default_nettype wire

// File: source/lsu_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_ctl
   import lsu_map_pkg::*;
   import lsu_pkt_pkg::*;
#(
   parameter int unsigned NUM_THREADS    = DEF_NUM_THREADS,
   parameter addr_t       DCCM_BASE      = DEF_DCCM_BASE,
   parameter int unsigned DCCM_SIZE_LOG2 = DEF_DCCM_SIZE_LOG2,
   parameter addr_t       PIC_BASE       = DEF_PIC_BASE,
   parameter int unsigned PIC_SIZE_LOG2  = DEF_PIC_SIZE_LOG2
)(
   input  logic                   clk,
   input  logic                   arst_n,
   input  lsu_pkt_t               lsu_p,
   input  addr_t                  rs1,
   input  offset_t                offset,
   input  logic [NUM_THREADS-1:0] flush_dc2_up,
   input  logic [NUM_THREADS-1:0] flush_dc3,
   input  logic [NUM_THREADS-1:0] flush_dc4,
   input  logic [NUM_THREADS-1:0] flush_dc5,
   input  logic [NUM_THREADS-1:0] lr_reset,
   input  data_t                  dccm_rdata,
   input  data_t                  pic_rdata,
   input  data_t                  bus_rdata,
   output addr_t                  lsu_addr_dc3,
   output lsu_region_t            region_dc3,
   output lsu_fault_t             fault_dc3,
   output data_t                  lsu_result_dc3,
   output logic                   lsu_commit_dc5,
   output logic                   sc_success_dc5,
   output logic [NUM_THREADS-1:0] lr_vld
);

   lsu_pkt_t    pkt_dc1;
   addr_t       addr_dc1;
   lsu_region_t region_dc1;
   lsu_fault_t  fault_dc1;
   lsu_pkt_t    pkt_dc3;
   lsu_pkt_t    pkt_dc5;
   addr_t       addr_dc5;

   // **********************************************************
   // dc1 address and decode
   // **********************************************************
   lsu_addr_gen #(
      .DCCM_BASE      (DCCM_BASE),
      .DCCM_SIZE_LOG2 (DCCM_SIZE_LOG2),
      .PIC_BASE       (PIC_BASE),
      .PIC_SIZE_LOG2  (PIC_SIZE_LOG2),
      .NUM_THREADS    (NUM_THREADS)
   ) lsu_addr_gen_inst (
      .clk          (clk),
      .arst_n       (arst_n),
      .lsu_p        (lsu_p),
      .rs1          (rs1),
      .offset       (offset),
      .flush_dc2_up (flush_dc2_up),
      .pkt_dc1      (pkt_dc1),
      .addr_dc1     (addr_dc1),
      .region_dc1   (region_dc1),
      .fault_dc1    (fault_dc1)
   );

   // dc2 through dc5
   lsu_pkt_pipe #(
      .NUM_THREADS (NUM_THREADS)
   ) lsu_pkt_pipe_inst (
      .clk          (clk),
      .arst_n       (arst_n),
      .pkt_dc1      (pkt_dc1),
      .addr_dc1     (addr_dc1),
      .region_dc1   (region_dc1),
      .fault_dc1    (fault_dc1),
      .flush_dc2_up (flush_dc2_up),
      .flush_dc3    (flush_dc3),
      .flush_dc4    (flush_dc4),
      .flush_dc5    (flush_dc5),
      .pkt_dc3      (pkt_dc3),
      .addr_dc3     (lsu_addr_dc3),
      .region_dc3   (region_dc3),
      .fault_dc3    (fault_dc3),
      .pkt_dc5      (pkt_dc5),
      .addr_dc5     (addr_dc5),
      .commit_dc5   (lsu_commit_dc5)
   );

   lsu_load_format lsu_load_format_inst (
      .pkt_dc3    (pkt_dc3),
      .region_dc3 (region_dc3),
      .dccm_rdata (dccm_rdata),
      .pic_rdata  (pic_rdata),
      .bus_rdata  (bus_rdata),
      .result_dc3 (lsu_result_dc3)
   );

   // LR/SC stations, updated off the dc5 commit
   lsu_reservation #(
      .NUM_THREADS (NUM_THREADS)
   ) lsu_reservation_inst (
      .clk            (clk),
      .arst_n         (arst_n),
      .pkt_dc5        (pkt_dc5),
      .addr_dc5       (addr_dc5),
      .commit_dc5     (lsu_commit_dc5),
      .lr_reset       (lr_reset),
      .sc_success_dc5 (sc_success_dc5),
      .lr_vld         (lr_vld)
   );

endmodule

`default_nettype wire

// File: source/lsu_load_format.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_format
   import lsu_map_pkg::*;
   import lsu_pkt_pkg::*;
(
   input  lsu_pkt_t    pkt_dc3,
   input  lsu_region_t region_dc3,
   input  data_t       dccm_rdata,
   input  data_t       pic_rdata,
   input  data_t       bus_rdata,
   output data_t       result_dc3
);

   data_t rdata_dc3;

   // Region is one hot, so an AND-OR mux is enough
   assign rdata_dc3 = ({32{region_dc3.in_dccm}}  & dccm_rdata) |
                      ({32{region_dc3.in_pic}}   & pic_rdata)  |
                      ({32{region_dc3.external}} & bus_rdata);

   always_comb begin
      result_dc3 = '0;
      if (pkt_dc3.valid & pkt_dc3.load) begin
         if (pkt_dc3.by) begin
            result_dc3 = pkt_dc3.unsign ? {24'b0, rdata_dc3[7:0]} :
                                          {{24{rdata_dc3[7]}}, rdata_dc3[7:0]};
         end else if (pkt_dc3.half) begin
            result_dc3 = pkt_dc3.unsign ? {16'b0, rdata_dc3[15:0]} :
                                          {{16{rdata_dc3[15]}}, rdata_dc3[15:0]};
         end else if (pkt_dc3.word) begin
            result_dc3 = rdata_dc3;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/lsu_map_pkg.sv
`default_nettype none

package lsu_map_pkg;

   // **********************************************************
   // Widths with a meaning
   // **********************************************************
   typedef logic [31:0] addr_t;      // Byte address
   typedef logic [31:0] data_t;      // Load data word
   typedef logic [11:0] offset_t;    // Immediate from decode
   typedef logic [29:0] line_addr_t; // Word address, bits 31:2

   // **********************************************************
   // Default thread count and memory map
   // **********************************************************
   localparam int unsigned DEF_NUM_THREADS = 2;

   // 64 KiB data closely coupled memory
   localparam addr_t       DEF_DCCM_BASE      = 32'hf004_0000;
   localparam int unsigned DEF_DCCM_SIZE_LOG2 = 16;

   // 32 KiB interrupt controller window
   localparam addr_t       DEF_PIC_BASE      = 32'hf00c_0000;
   localparam int unsigned DEF_PIC_SIZE_LOG2 = 15;

endpackage

`default_nettype wire

// File: source/lsu_pkt_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_pkt_pipe
   import lsu_map_pkg::*;
   import lsu_pkt_pkg::*;
#(
   parameter int unsigned NUM_THREADS = DEF_NUM_THREADS
)(
   input  logic                   clk,
   input  logic                   arst_n,
   input  lsu_pkt_t               pkt_dc1,
   input  addr_t                  addr_dc1,
   input  lsu_region_t            region_dc1,
   input  lsu_fault_t             fault_dc1,
   input  logic [NUM_THREADS-1:0] flush_dc2_up,
   input  logic [NUM_THREADS-1:0] flush_dc3,
   input  logic [NUM_THREADS-1:0] flush_dc4,
   input  logic [NUM_THREADS-1:0] flush_dc5,
   output lsu_pkt_t               pkt_dc3,
   output addr_t                  addr_dc3,
   output lsu_region_t            region_dc3,
   output lsu_fault_t             fault_dc3,
   output lsu_pkt_t               pkt_dc5,
   output addr_t                  addr_dc5,
   output logic                   commit_dc5
);

   // Index is the stage the entry lands in
   lsu_pkt_t    [5:2] pkt_in;
   lsu_pkt_t    [5:2] pkt_q;
   addr_t       [5:2] addr_q;
   lsu_region_t [3:2] region_q;
   lsu_fault_t  [3:2] fault_q;

   // **********************************************************
   // Per-stage flush of the packet valid
   // **********************************************************
   always_comb begin
      pkt_in[2] = pkt_dc1;
      pkt_in[3] = pkt_q[2];
      pkt_in[4] = pkt_q[3];
      pkt_in[5] = pkt_q[4];

      pkt_in[2].valid = pkt_dc1.valid  & ~flush_dc2_up[pkt_dc1.tid];
      pkt_in[3].valid = pkt_q[2].valid & ~flush_dc2_up[pkt_q[2].tid];
      pkt_in[4].valid = pkt_q[3].valid & ~flush_dc3[pkt_q[3].tid];
      pkt_in[5].valid = pkt_q[4].valid & ~flush_dc4[pkt_q[4].tid];
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pkt_q    <= '0;
         region_q <= '0;
         fault_q  <= '0;
      end else begin
         pkt_q    <= pkt_in;
         region_q <= {region_q[2], region_dc1};
         fault_q  <= {fault_q[2], fault_dc1};
      end
   end

   // Address shifts down unqualified
   always_ff @(posedge clk) begin
      addr_q <= {addr_q[4:2], addr_dc1};
   end

   // **********************************************************
   // Stage taps
   // **********************************************************
   assign pkt_dc3    = pkt_q[3];
   assign addr_dc3   = addr_q[3];
   assign region_dc3 = region_q[3];
   assign fault_dc3  = fault_q[3];

   assign pkt_dc5  = pkt_q[5];
   assign addr_dc5 = addr_q[5];

   // Late flush still blocks the writeback
   assign commit_dc5 = pkt_q[5].valid &
                       (pkt_q[5].load | pkt_q[5].store | pkt_q[5].atomic) &
                       ~flush_dc5[pkt_q[5].tid];

endmodule

`default_nettype wire

// File: source/lsu_pkt_pkg.sv
`default_nettype none

package lsu_pkt_pkg;

   // **********************************************************
   // Control packet from decode
   // **********************************************************
   typedef struct packed {
      logic tid;    // Thread id, up to 2 threads
      logic load;
      logic store;
      logic unsign; // Zero extend the load
      logic by;
      logic half;
      logic word;
      logic atomic;
      logic lr;     // Load reserved
      logic sc;     // Store conditional
      logic valid;
   } lsu_pkt_t;

   // One hot, exactly one set
   typedef struct packed {
      logic in_dccm;
      logic in_pic;
      logic external;
   } lsu_region_t;

   typedef struct packed {
      logic misaligned;
      logic access;
   } lsu_fault_t;

endpackage

`default_nettype wire

// File: source/lsu_reservation.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_reservation
   import lsu_map_pkg::*;
   import lsu_pkt_pkg::*;
#(
   parameter int unsigned NUM_THREADS = DEF_NUM_THREADS
)(
   input  logic                   clk,
   input  logic                   arst_n,
   input  lsu_pkt_t               pkt_dc5,
   input  addr_t                  addr_dc5,
   input  logic                   commit_dc5,
   input  logic [NUM_THREADS-1:0] lr_reset,
   output logic                   sc_success_dc5,
   output logic [NUM_THREADS-1:0] lr_vld
);

   line_addr_t [NUM_THREADS-1:0] lr_addr;    // One station per thread
   line_addr_t                   line_dc5;
   logic       [NUM_THREADS-1:0] own_thread;
   logic       [NUM_THREADS-1:0] line_match;
   logic       [NUM_THREADS-1:0] sc_match;
   logic       [NUM_THREADS-1:0] lr_set;
   logic       [NUM_THREADS-1:0] lr_clr;

   assign line_dc5 = addr_dc5[31:2];

   // **********************************************************
   // SC match and station set/clear
   // **********************************************************
   always_comb begin
      for (int i = 0; i < NUM_THREADS; i++) begin
         own_thread[i] = (i == int'(pkt_dc5.tid));
         // Station address only counts while it is valid
         line_match[i] = lr_vld[i] & (line_dc5 == lr_addr[i]);
         sc_match[i]   = own_thread[i] & pkt_dc5.valid & pkt_dc5.sc & line_match[i];
      end
   end

   assign sc_success_dc5 = |sc_match;  // Not gated by commit

   always_comb begin
      for (int i = 0; i < NUM_THREADS; i++) begin
         lr_set[i] = own_thread[i] & commit_dc5 & pkt_dc5.lr;
         lr_clr[i] = (own_thread[i] & commit_dc5 & pkt_dc5.sc) |
                     (~own_thread[i] & commit_dc5 & pkt_dc5.store &
                      (~pkt_dc5.sc | sc_success_dc5) & line_match[i]) |
                     lr_reset[i];   // Traps, debug and the like
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lr_vld <= '0;
      end else begin
         for (int i = 0; i < NUM_THREADS; i++) begin
            if (lr_clr[i]) begin
               lr_vld[i] <= 1'b0;   // Clear wins
            end else if (lr_set[i]) begin
               lr_vld[i] <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_THREADS; i++) begin
         if (lr_set[i]) begin
            lr_addr[i] <= line_dc5;
         end
      end
   end

endmodule

`default_nettype wire
